// File: sources.f
+incdir+logic
logic/cpuPkg.sv
logic/memBus.sv
logic/regFile.sv
logic/alu.sv
logic/controlUnit.sv
logic/datapath.sv
logic/memArbiter.sv
logic/unifiedMemory.sv
logic/cpuTop.sv
verif/cpuTb.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sources.f --top-module cpuTb -o cpuSim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpuSim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/cpu_vectors.txt
// columns: kind, address, data word, all hex.
// kinds: 1 load, 2 run (host reads address..address+word-1 while it runs),
// 3 expect, 4 end of test, f end of vectors.
1 a0 1234
1 a1 abcd
1 a2 0f0f
1 a3 8001
3 a0 1234
3 a1 abcd
3 a2 0f0f
3 a3 8001
4 00 0000
1 00 6200
1 01 6012
1 02 5034
1 03 49f0
1 04 f1c0
1 05 8b40
1 06 f1c1
1 07 8b41
1 08 f1c2
1 09 8b42
1 0a f1c3
1 0b 8b43
1 0c f0c4
1 0d 8b44
1 0e f4c5
1 0f 8b45
1 10 f0c6
1 11 8b46
1 12 f4c7
1 13 8b47
1 14 f01d
2 00 0000
3 40 1224
3 41 1244
3 42 1230
3 43 fff4
3 44 edcb
3 45 0010
3 46 2468
3 47 fff8
4 00 0000
1 50 eeee
1 51 eeee
1 52 eeee
1 53 eeee
1 54 eeee
1 55 eeee
1 00 6200
1 01 4805
1 02 49fd
1 03 0101
1 04 8850
1 05 1001
1 06 8851
1 07 2401
1 08 8852
1 09 3401
1 0a 8853
1 0b 2001
1 0c 8954
1 0d 0001
1 0e 8955
1 0f f01d
2 00 0000
3 50 eeee
3 51 eeee
3 52 0005
3 53 eeee
3 54 eeee
3 55 fffd
4 00 0000
1 60 7777
1 00 6300
1 01 9004
1 02 8f60
1 04 a008
1 05 8f60
1 08 8e61
1 09 4c0c
1 0a f01a
1 0b 8f60
1 0c 8e62
1 0d 4d10
1 0e f419
1 0f 8f60
1 10 f01d
2 00 0000
3 60 7777
3 61 0005
3 62 000b
4 00 0000
1 70 0011
1 71 0102
1 72 f000
1 73 0fff
1 00 6000
1 01 6100
1 02 4304
1 03 7270
1 04 f640
1 05 8180
1 06 4001
1 07 03fb
1 08 f01d
2 a0 0004
3 80 0011
3 81 0113
3 82 f113
3 83 0112
4 00 0000
f 00 0000

// File: verif/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int MAX_RECORDS = 160;
    localparam int CYCLES_PER_RECORD = 400;
    localparam logic [31:0] LFSR_SEED = 32'h68a9_6bf4;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // record kinds in the vectors file.
    localparam logic [15:0] REC_LOAD = 16'h0001;
    localparam logic [15:0] REC_RUN = 16'h0002;
    localparam logic [15:0] REC_EXPECT = 16'h0003;
    localparam logic [15:0] REC_END_TEST = 16'h0004;
    localparam logic [15:0] REC_LAST = 16'h000f;

    logic clk;
    logic rst;
    logic run;
    logic hostReqValid;
    logic hostReqWrite;
    addr_t hostReqAddr;
    word_t hostReqData;
    logic hostCredit;
    logic hostRspValid;
    word_t hostRspData;
    logic halted;

    logic [15:0] vectors [3*MAX_RECORDS];
    // words the host has loaded for reads during a run.
    word_t image [`MEM_DEPTH];
    logic known [`MEM_DEPTH];
    word_t expData [$];
    addr_t expAddr [$];
    int hostCredits = `PORT_CREDITS;
    int cycles = 0;
    int cycleLimit = 0;
    logic [31:0] lfsr;

    cpuTop cpuTop_inst (
        .clk(clk),
        .rst(rst),
        .run(run),
        .hostReqValid(hostReqValid),
        .hostReqWrite(hostReqWrite),
        .hostReqAddr(hostReqAddr),
        .hostReqData(hostReqData),
        .hostCredit(hostCredit),
        .hostRspValid(hostRspValid),
        .hostRspData(hostRspData),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Fail %s: got %h, expected %h", name, got, expected);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[6:0], lfsr[0]};
            lfsr = stepLfsr(lfsr);
        end
        return bits;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            abortRun("simulation ran past its cycle limit");
        end
    end

    // credit bookkeeping and in-order response check.
    always @(negedge clk) begin
        if (!rst) begin
            hostCredits = hostCredits - int'(hostReqValid) + int'(hostCredit);
            if (hostCredits > `PORT_CREDITS) begin
                abortRun("host credit returned with no request outstanding");
            end
            if (hostRspValid) begin
                if (expData.size() == 0) begin
                    abortRun("host response arrived with no read outstanding");
                end else begin
                    checkValue($sformatf("hostRspData[%h]", expAddr[0]), hostRspData,
                               expData[0]);
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
            end
        end
    end

    // called and returns 1 ns after a rising edge.
    task automatic issueRequest(input logic write, input addr_t addr, input word_t data);
        while (hostCredits == 0) begin
            @(posedge clk);
            #1;
        end
        hostReqValid = 1'b1;
        hostReqWrite = write;
        hostReqAddr = addr;
        hostReqData = data;
        @(posedge clk);
        #1;
        hostReqValid = 1'b0;
    endtask

    task automatic hostWrite(input addr_t addr, input word_t data);
        image[addr] = data;
        known[addr] = 1'b1;
        issueRequest(1'b1, addr, data);
    endtask

    task automatic hostRead(input addr_t addr, input word_t expected);
        expAddr.push_back(addr);
        expData.push_back(expected);
        issueRequest(1'b0, addr, '0);
    endtask

    // all credits back and no read outstanding.
    task automatic drainHost();
        while (hostCredits != `PORT_CREDITS || expData.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runProgram(input addr_t base, input int count);
        addr_t addr;
        logic [7:0] gap;
        drainHost();
        checkValue("halted", word_t'(halted), 16'h0000);
        run = 1'b1;
        while (!halted) begin
            if (count == 0) begin
                @(posedge clk);
                #1;
            end else begin
                gap = takeBits(3);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                addr = base + addr_t'(takeBits(8) % count);
                if (!known[addr]) begin
                    abortRun("host read during the run hit an address never loaded");
                end
                hostRead(addr, image[addr]);
            end
        end
        // halted stays up while run is held.
        @(posedge clk);
        #1;
        checkValue("halted", word_t'(halted), 16'h0001);
        run = 1'b0;
        drainHost();
    endtask

    initial begin
        int records;
        int tests;
        logic [15:0] kind;
        addr_t addr;
        word_t word;
        rst = 1'b1;
        run = 1'b0;
        hostReqValid = 1'b0;
        hostReqWrite = 1'b0;
        hostReqAddr = '0;
        hostReqData = '0;
        lfsr = LFSR_SEED;
        tests = 0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            known[i] = 1'b0;
        end
        $readmemh("verif/cpu_vectors.txt", vectors);
        records = 0;
        while (records < MAX_RECORDS && vectors[3*records] !== REC_LAST) begin
            records++;
        end
        if (records == MAX_RECORDS) begin
            abortRun("vectors file has no end marker");
        end
        cycleLimit = CYCLES_PER_RECORD * (records + 1);

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < records; r++) begin
            kind = vectors[3*r];
            addr = addr_t'(vectors[3*r+1]);
            word = vectors[3*r+2];
            case (kind)
                REC_LOAD: hostWrite(addr, word);
                REC_RUN: runProgram(addr, int'(word));
                REC_EXPECT: hostRead(addr, word);
                REC_END_TEST: begin
                    drainHost();
                    tests++;
                    $display("test %0d done", tests);
                end
                default: abortRun($sformatf("unknown record kind %h in record %0d", kind, r));
            endcase
        end
        drainHost();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input logic clk,
    input logic rst,
    input logic run,
    input logic hostReqValid,
    input logic hostReqWrite,
    input cpuPkg::addr_t hostReqAddr,
    input cpuPkg::word_t hostReqData,
    output logic hostCredit,
    output logic hostRspValid,
    output cpuPkg::word_t hostRspData,
    output logic halted
);
    import cpuPkg::*;

    memBus coreBus ();
    memBus hostBus ();

    logic memValid;
    logic memWrite;
    addr_t memAddr;
    word_t memWdata;
    word_t memRdata;

    // host pins onto the second arbiter port.
    assign hostBus.reqValid = hostReqValid;
    assign hostBus.reqWrite = hostReqWrite;
    assign hostBus.reqAddr = hostReqAddr;
    assign hostBus.reqData = hostReqData;
    assign hostCredit = hostBus.credit;
    assign hostRspValid = hostBus.rspValid;
    assign hostRspData = hostBus.rspData;

    datapath datapath_inst (
        .clk(clk),
        .rst(rst),
        .run(run),
        .mem(coreBus.requester),
        .halted(halted)
    );

    memArbiter memArbiter_inst (
        .clk(clk),
        .rst(rst),
        .core(coreBus.arbiter),
        .host(hostBus.arbiter),
        .memValid(memValid),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memRdata(memRdata)
    );

    unifiedMemory unifiedMemory_inst (
        .clk(clk),
        .valid(memValid),
        .write(memWrite),
        .addr(memAddr),
        .wdata(memWdata),
        .rdata(memRdata)
    );

endmodule

// File: logic/unifiedMemory.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module unifiedMemory (
    input logic clk,
    input logic valid,
    input logic write,
    input cpuPkg::addr_t addr,
    input cpuPkg::word_t wdata,
    output cpuPkg::word_t rdata
);
    import cpuPkg::*;

    word_t mem [`MEM_DEPTH];

    // registered read, data valid the next cycle.
    always_ff @(posedge clk) begin
        if (valid) begin
            if (write) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: logic/memArbiter.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memArbiter (
    input logic clk,
    input logic rst,
    memBus.arbiter core,
    memBus.arbiter host,
    output logic memValid,
    output logic memWrite,
    output cpuPkg::addr_t memAddr,
    output cpuPkg::word_t memWdata,
    input cpuPkg::word_t memRdata
);
    import cpuPkg::*;

    localparam int NUM_PORTS = 2;
    localparam int PTR_W = (`PORT_CREDITS > 1) ? $clog2(`PORT_CREDITS) : 1;

    typedef struct packed {
        logic write;
        addr_t addr;
        word_t data;
    } req_t;

    typedef logic [PTR_W-1:0] ptr_t;

    req_t inReq [NUM_PORTS];
    req_t fifo [NUM_PORTS][`PORT_CREDITS];
    ptr_t wrPtr [NUM_PORTS];
    ptr_t rdPtr [NUM_PORTS];
    credit_t count [NUM_PORTS];
    logic [NUM_PORTS-1:0] inValid;
    logic [NUM_PORTS-1:0] notEmpty;
    logic [NUM_PORTS-1:0] grant;
    logic rrPtr;
    logic pick;
    logic rdPending;
    logic rdSrc;

    function automatic ptr_t bump(ptr_t p);
        return (p == ptr_t'(`PORT_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    // port 0 is the core, port 1 the host.
    assign inValid = {host.reqValid, core.reqValid};
    assign inReq[0] = '{core.reqWrite, core.reqAddr, core.reqData};
    assign inReq[1] = '{host.reqWrite, host.reqAddr, host.reqData};

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            notEmpty[p] = count[p] != '0;
        end
    end

    // rrPtr picks the winner only when both ports wait.
    assign pick = notEmpty[0] ? (notEmpty[1] & rrPtr) : 1'b1;
    assign memValid = |notEmpty;
    assign grant = memValid ? (pick ? 2'b10 : 2'b01) : 2'b00;
    assign {memWrite, memAddr, memWdata} = fifo[pick][rdPtr[pick]];

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (inValid[p]) begin
                fifo[p][wrPtr[p]] <= inReq[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wrPtr[p] <= '0;
                rdPtr[p] <= '0;
                count[p] <= '0;
            end
            rrPtr <= 1'b0;
            rdPending <= 1'b0;
            rdSrc <= 1'b0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (inValid[p]) begin
                    wrPtr[p] <= bump(wrPtr[p]);
                end
                if (grant[p]) begin
                    rdPtr[p] <= bump(rdPtr[p]);
                end
                count[p] <= count[p] + credit_t'(inValid[p]) - credit_t'(grant[p]);
            end
            if (memValid) begin
                rrPtr <= ~pick;
            end
            // read data shows up one cycle after the grant.
            rdPending <= memValid && !memWrite;
            rdSrc <= pick;
        end
    end

    assign core.credit = grant[0];
    assign host.credit = grant[1];
    assign core.rspValid = rdPending && !rdSrc;
    assign host.rspValid = rdPending && rdSrc;
    assign core.rspData = memRdata;
    assign host.rspData = memRdata;

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath (
    input logic clk,
    input logic rst,
    input logic run,
    memBus.requester mem,
    output logic halted
);
    import cpuPkg::*;

    coreState_t state;
    word_t pc;
    word_t ir;
    credit_t credits;
    ctrl_t ctrl;
    opcode_t opcode;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    regIdx_t wr;
    word_t rdata1;
    word_t rdata2;
    word_t wdata;
    word_t immExt;
    word_t aluB;
    word_t aluResult;
    word_t pcPlus1;
    word_t nextPc;
    logic haveCredit;
    logic memAccess;
    logic issue;
    logic branchTaken;
    logic we;

    assign opcode = ir[15:12];
    assign rs = ir[11:10];
    assign rt = ir[9:8];
    assign rd = ir[7:6];
    assign wr = ctrl.link ? LINK_REG : (ctrl.regDst ? rd : rt);

    // ori zero-extends, everything else sign-extends.
    assign immExt = (opcode == OP_ORI) ? {{(`WORD_WIDTH - 8){1'b0}}, ir[7:0]}
                                       : {{(`WORD_WIDTH - 8){ir[7]}}, ir[7:0]};
    assign aluB = ctrl.aluSrc ? immExt : rdata2;
    assign pcPlus1 = pc + 1'b1;
    assign wdata = ctrl.link ? pcPlus1 : (ctrl.memToReg ? mem.rspData : aluResult);

    // loads write back when their data returns.
    assign we = ctrl.regWrite &&
                ((state == EXEC && !ctrl.memRead) || (state == WAITD && mem.rspValid));

    controlUnit controlUnit_inst (
        .instr(ir),
        .ctrl(ctrl)
    );

    regFile regFile_inst (
        .clk(clk),
        .rst(rst),
        .rs(rs),
        .rt(rt),
        .wr(wr),
        .wdata(wdata),
        .we(we),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    alu alu_inst (
        .a(rdata1),
        .b(aluB),
        .op(ctrl.aluOp),
        .result(aluResult)
    );

    always_comb begin
        case (opcode)
            OP_BNE: branchTaken = rdata1 != rdata2;
            OP_BEQ: branchTaken = rdata1 == rdata2;
            OP_BGZ: branchTaken = $signed(rdata1) > 0;
            OP_BLZ: branchTaken = $signed(rdata1) < 0;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.jump) begin
            // jpr and jrl take rs, jmp and jal keep the top pc bits.
            nextPc = (opcode == OP_RTYPE) ? rdata1 : {pc[`WORD_WIDTH-1:12], ir[11:0]};
        end else if (ctrl.branch && branchTaken) begin
            nextPc = pcPlus1 + immExt;
        end else begin
            nextPc = pcPlus1;
        end
    end

    assign haveCredit = credits != '0;
    assign memAccess = ctrl.memRead || ctrl.memWrite;
    assign issue = haveCredit && (state == FETCH || (state == EXEC && memAccess));

    assign mem.reqValid = issue;
    assign mem.reqWrite = (state == EXEC) && ctrl.memWrite;
    assign mem.reqAddr = (state == FETCH) ? pc[`ADDR_WIDTH-1:0] : aluResult[`ADDR_WIDTH-1:0];
    assign mem.reqData = rdata2;
    assign halted = state == HALT;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(`PORT_CREDITS);
        end else begin
            credits <= credits - credit_t'(issue) + credit_t'(mem.credit);
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAITI && mem.rspValid) begin
            ir <= mem.rspData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // each run starts from address zero.
                    if (run) begin
                        pc <= '0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (haveCredit) begin
                        state <= WAITI;
                    end
                end
                WAITI: begin
                    if (mem.rspValid) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (ctrl.halt) begin
                        state <= HALT;
                    end else if (!memAccess || haveCredit) begin
                        pc <= nextPc;
                        state <= ctrl.memRead ? WAITD : FETCH;
                    end
                end
                WAITD: begin
                    if (mem.rspValid) begin
                        state <= FETCH;
                    end
                end
                HALT: begin
                    if (!run) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input cpuPkg::word_t instr,
    output cpuPkg::ctrl_t ctrl
);
    import cpuPkg::*;

    opcode_t opcode;
    func_t func;

    assign opcode = instr[15:12];
    assign func = instr[5:0];

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = ALU_ADD;
        case (opcode)
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
                ctrl.branch = 1'b1;
            end
            OP_ADI, OP_ORI, OP_LHI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                if (opcode == OP_ORI) begin
                    ctrl.aluOp = ALU_OR;
                end else if (opcode == OP_LHI) begin
                    ctrl.aluOp = ALU_LHI;
                end
            end
            OP_LWD: begin
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            OP_SWD: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            OP_JMP: begin
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_RTYPE: begin
                if (func <= FN_SHR) begin
                    ctrl.regDst = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = aluOp_t'(func[3:0]);
                end else if (func == FN_JPR) begin
                    ctrl.jump = 1'b1;
                end else if (func == FN_JRL) begin
                    ctrl.jump = 1'b1;
                    ctrl.link = 1'b1;
                    ctrl.regWrite = 1'b1;
                end else if (func == FN_HLT) begin
                    ctrl.halt = 1'b1;
                end
            end
            default: begin
                ctrl.aluOp = ALU_ADD;
            end
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input cpuPkg::word_t a,
    input cpuPkg::word_t b,
    input cpuPkg::aluOp_t op,
    output cpuPkg::word_t result
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_NOT: begin
                result = ~a;
            end
            ALU_TCP: begin
                result = ~a + 1'b1;
            end
            ALU_SHL: begin
                result = a << 1;
            end
            // arithmetic shift, sign bit kept.
            ALU_SHR: begin
                result = word_t'($signed(a) >>> 1);
            end
            ALU_LHI: begin
                result = {b[7:0], 8'h00};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
    input logic clk,
    input logic rst,
    input cpuPkg::regIdx_t rs,
    input cpuPkg::regIdx_t rt,
    input cpuPkg::regIdx_t wr,
    input cpuPkg::word_t wdata,
    input logic we,
    output cpuPkg::word_t rdata1,
    output cpuPkg::word_t rdata2
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    assign rdata1 = regs[rs];
    assign rdata2 = regs[rt];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr] <= wdata;
        end
    end

endmodule

// File: logic/memBus.sv
`timescale 1ns/1ps

interface memBus;
    import cpuPkg::*;

    logic reqValid;
    logic reqWrite;
    addr_t reqAddr;
    word_t reqData;
    // one pulse per freed buffer entry.
    logic credit;
    logic rspValid;
    word_t rspData;

    modport requester (
        output reqValid, reqWrite, reqAddr, reqData,
        input credit, rspValid, rspData
    );

    modport arbiter (
        input reqValid, reqWrite, reqAddr, reqData,
        output credit, rspValid, rspData
    );

endinterface

// File: logic/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;
    typedef logic [3:0] opcode_t;
    typedef logic [5:0] func_t;
    typedef logic [$clog2(`PORT_CREDITS + 1)-1:0] credit_t;

    // instruction opcodes.
    localparam opcode_t OP_BNE = 4'd0;
    localparam opcode_t OP_BEQ = 4'd1;
    localparam opcode_t OP_BGZ = 4'd2;
    localparam opcode_t OP_BLZ = 4'd3;
    localparam opcode_t OP_ADI = 4'd4;
    localparam opcode_t OP_ORI = 4'd5;
    localparam opcode_t OP_LHI = 4'd6;
    localparam opcode_t OP_LWD = 4'd7;
    localparam opcode_t OP_SWD = 4'd8;
    localparam opcode_t OP_JMP = 4'd9;
    localparam opcode_t OP_JAL = 4'd10;
    localparam opcode_t OP_RTYPE = 4'd15;

    // r-type function codes; 0 to 7 match the alu encoding.
    localparam func_t FN_SHR = 6'd7;
    localparam func_t FN_JPR = 6'd25;
    localparam func_t FN_JRL = 6'd26;
    localparam func_t FN_HLT = 6'd29;

    // link register for jal and jrl.
    localparam regIdx_t LINK_REG = 2'd2;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR = 4'd3,
        ALU_NOT = 4'd4,
        ALU_TCP = 4'd5,
        ALU_SHL = 4'd6,
        ALU_SHR = 4'd7,
        ALU_LHI = 4'd8
    } aluOp_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAITI,
        EXEC,
        WAITD,
        HALT
    } coreState_t;

    typedef struct packed {
        logic jump;
        logic branch;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic regDst;
        logic regWrite;
        aluOp_t aluOp;
        logic aluSrc;
        logic link;
        logic halt;
    } ctrl_t;

endpackage

// File: logic/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data word width.
`define WORD_WIDTH 16

// memory address width, 256 words.
`define ADDR_WIDTH 8

// general register count.
`define REG_COUNT 4

// words in the unified memory.
`define MEM_DEPTH 256

// request buffer entries per arbiter port.
`define PORT_CREDITS 2

`endif
